//--- rtl/tile_pkg.sv
`default_nettype none

package tile_pkg;

    // Pixel format
    localparam int PIXEL_W = 8;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // Default geometry, overridden from the top level
    localparam int DEF_CHANNELS = 3;
    localparam int DEF_WIDTH    = 10;
    localparam int DEF_TILE     = 4;
    localparam int DEF_STRIDE   = 2;

    // Bank sequencer
    typedef enum logic [0:0] {
        SEQ_INIT_FILL,
        SEQ_STREAM
    } seq_state_e;

    // Output side, one state per handshake phase
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_WAIT_ACK_LOW
    } hs_state_e;

endpackage

`default_nettype wire

//--- rtl/row_bank_if.sv
`timescale 1ns/100ps
`default_nettype none

interface row_bank_if import tile_pkg::*; #(
    parameter int CHANNELS = DEF_CHANNELS,
    parameter int WIDTH    = DEF_WIDTH,
    parameter int TILE     = DEF_TILE,
    parameter int STRIDE   = DEF_STRIDE
) ();

    localparam int SLOT_W = $clog2(TILE + STRIDE);
    localparam int ADDR_W = $clog2(CHANNELS * WIDTH);
    localparam int COL_W  = $clog2(WIDTH);
    localparam int ROWS_W = CHANNELS * TILE * TILE * PIXEL_W;

    // Write side
    logic              wr_en;
    logic [SLOT_W-1:0] wr_slot;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_pixel;

    // Read request, base slot is the oldest row of the band
    logic              rd_en;
    logic [SLOT_W-1:0] rd_base_slot;
    logic [COL_W-1:0]  rd_col;

    // Read return in tile layout
    logic [ROWS_W-1:0] rd_rows;
    logic              rd_valid;

    modport seq (
        output wr_en, wr_slot, wr_addr, wr_pixel,
        output rd_en, rd_base_slot, rd_col
    );

    modport bank (
        input  wr_en, wr_slot, wr_addr, wr_pixel,
        input  rd_en, rd_base_slot, rd_col,
        output rd_rows, rd_valid
    );

endinterface

`default_nettype wire

//--- rtl/row_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module row_buffer import tile_pkg::*; #(
    parameter int CHANNELS = DEF_CHANNELS,
    parameter int WIDTH    = DEF_WIDTH,
    parameter int TILE     = DEF_TILE
) (
    input  wire logic                                i_clk,
    input  wire logic                                i_rst,
    input  wire logic                                i_wr_en,
    input  wire logic [$clog2(CHANNELS*WIDTH)-1:0]   i_wr_addr,
    input  wire pixel_t                              i_wr_pixel,
    input  wire logic                                i_rd_en,
    input  wire logic [$clog2(WIDTH)-1:0]            i_rd_col,
    output logic      [CHANNELS*TILE*PIXEL_W-1:0]    o_rd_data
);

    localparam int ROW_PIX = CHANNELS * WIDTH;

    // Channels stored back to back, as they arrive
    pixel_t row_mem [ROW_PIX];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            row_mem[i_wr_addr] <= i_wr_pixel;
        end
    end

    // TILE pixels from every channel section, starting at i_rd_col
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            for (int ch = 0; ch < CHANNELS; ch++) begin
                for (int k = 0; k < TILE; k++) begin
                    o_rd_data[(ch*TILE + k)*PIXEL_W +: PIXEL_W] <=
                        row_mem[ch*WIDTH + int'(i_rd_col) + k];
                end
            end
        end
    end

    // Window must stay inside the row of each channel
    a_rd_in_row: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_rd_en |-> (int'(i_rd_col) + TILE <= WIDTH)
    ) else $error("row_buffer read window past end of row, col %0d", i_rd_col);

endmodule

`default_nettype wire

//--- rtl/row_bank.sv
`timescale 1ns/100ps
`default_nettype none

module row_bank import tile_pkg::*; #(
    parameter int CHANNELS = DEF_CHANNELS,
    parameter int WIDTH    = DEF_WIDTH,
    parameter int TILE     = DEF_TILE,
    parameter int STRIDE   = DEF_STRIDE
) (
    input wire logic i_clk,
    input wire logic i_rst,
    row_bank_if.bank bus
);

    localparam int SLOTS    = TILE + STRIDE;
    localparam int SLOT_W   = $clog2(SLOTS);
    localparam int SLICE_W  = CHANNELS * TILE * PIXEL_W;

    typedef logic [SLOT_W-1:0]  slot_t;
    typedef logic [SLICE_W-1:0] slice_t;

    slice_t slot_data [SLOTS];
    slot_t  base_q;

    for (genvar s = 0; s < SLOTS; s++) begin : g_slot
        row_buffer #(
            .CHANNELS (CHANNELS),
            .WIDTH    (WIDTH),
            .TILE     (TILE)
        ) u_row_buffer (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_wr_en    (bus.wr_en && (bus.wr_slot == slot_t'(s))),
            .i_wr_addr  (bus.wr_addr),
            .i_wr_pixel (bus.wr_pixel),
            .i_rd_en    (bus.rd_en),
            .i_rd_col   (bus.rd_col),
            .o_rd_data  (slot_data[s])
        );
    end

    // Base slot travels with the read so ordering matches the data
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            base_q       <= '0;
            bus.rd_valid <= 1'b0;
        end else begin
            bus.rd_valid <= bus.rd_en;
            if (bus.rd_en) begin
                base_q <= bus.rd_base_slot;
            end
        end
    end

    // Oldest row first, wrapping around the slot ring
    always_comb begin
        int slot;
        for (int r = 0; r < TILE; r++) begin
            slot = int'(base_q) + r;
            if (slot >= SLOTS) begin
                slot = slot - SLOTS;
            end
            for (int ch = 0; ch < CHANNELS; ch++) begin
                for (int k = 0; k < TILE; k++) begin
                    bus.rd_rows[((ch*TILE + r)*TILE + k)*PIXEL_W +: PIXEL_W] =
                        slot_data[slot][(ch*TILE + k)*PIXEL_W +: PIXEL_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/bank_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module bank_sequencer import tile_pkg::*; #(
    parameter int CHANNELS = DEF_CHANNELS,
    parameter int WIDTH    = DEF_WIDTH,
    parameter int TILE     = DEF_TILE,
    parameter int STRIDE   = DEF_STRIDE
) (
    input  wire logic   i_clk,
    input  wire logic   i_rst,
    input  wire logic   i_restart,
    input  wire pixel_t i_pixel,
    input  wire logic   i_pixel_valid,
    output logic        o_pixel_ready,
    input  wire logic   i_free,
    row_bank_if.seq     bus
);

    localparam int SLOTS   = TILE + STRIDE;
    localparam int PHASES  = SLOTS / STRIDE;
    localparam int ROW_PIX = CHANNELS * WIDTH;
    localparam int COL_END = WIDTH - TILE + STRIDE;

    typedef logic [$clog2(SLOTS)-1:0]          slot_t;
    typedef logic [$clog2(PHASES)-1:0]         phase_t;
    typedef logic [$clog2(ROW_PIX)-1:0]        addr_t;
    typedef logic [$clog2(TILE+1)-1:0]         fill_t;
    typedef logic [$clog2(WIDTH+STRIDE)-1:0]   cnt_t;
    typedef logic [$clog2(WIDTH)-1:0]          col_t;

    seq_state_e state_q;
    addr_t      pix_q;
    fill_t      fill_q;
    slot_t      wr_slot_q;
    phase_t     phase_q;
    cnt_t       col_q;

    slot_t      base_slot;
    logic       accept;
    logic       row_end;
    logic       fills_done;
    logic       reads_done;
    logic       advance;
    int         wr_offset;

    // Geometry the column stepping and phase rotation rely on
    if ((WIDTH - TILE) % STRIDE != 0) begin : g_bad_stride
        $error("WIDTH - TILE must be a multiple of STRIDE");
    end
    if (TILE % STRIDE != 0) begin : g_bad_phase
        $error("TILE must be a multiple of STRIDE");
    end

    assign base_slot  = slot_t'(int'(phase_q) * STRIDE);
    assign fills_done = (fill_q == fill_t'(STRIDE));
    assign reads_done = (col_q == cnt_t'(COL_END));
    assign advance    = (state_q == SEQ_STREAM) && fills_done && reads_done;

    // Hold input once the next band's rows are in and the current one is still read
    assign o_pixel_ready = (state_q == SEQ_INIT_FILL) || !fills_done;
    assign accept        = i_pixel_valid && o_pixel_ready;
    assign row_end       = accept && (pix_q == addr_t'(ROW_PIX - 1));

    assign bus.wr_en    = accept;
    assign bus.wr_slot  = wr_slot_q;
    assign bus.wr_addr  = pix_q;
    assign bus.wr_pixel = i_pixel;

    assign bus.rd_en        = (state_q == SEQ_STREAM) && !reads_done && i_free;
    assign bus.rd_base_slot = base_slot;
    assign bus.rd_col       = col_t'(col_q);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q   <= SEQ_INIT_FILL;
            pix_q     <= '0;
            fill_q    <= '0;
            wr_slot_q <= '0;
            phase_q   <= '0;
            col_q     <= '0;
        end else if (i_restart) begin
            state_q   <= SEQ_INIT_FILL;
            pix_q     <= '0;
            fill_q    <= '0;
            wr_slot_q <= '0;
            phase_q   <= '0;
            col_q     <= '0;
        end else begin
            if (accept) begin
                pix_q <= row_end ? '0 : addr_t'(pix_q + 1'b1);
            end
            if (row_end) begin
                wr_slot_q <= (wr_slot_q == slot_t'(SLOTS - 1)) ? '0 : slot_t'(wr_slot_q + 1'b1);
            end
            if (bus.rd_en) begin
                col_q <= cnt_t'(col_q + STRIDE);
            end

            case (state_q)
                SEQ_INIT_FILL: begin
                    if (row_end) begin
                        if (fill_q == fill_t'(TILE - 1)) begin
                            fill_q  <= '0;
                            state_q <= SEQ_STREAM;
                        end else begin
                            fill_q <= fill_t'(fill_q + 1'b1);
                        end
                    end
                end
                SEQ_STREAM: begin
                    // Band fully read and next rows in, rotate by STRIDE rows
                    if (advance) begin
                        fill_q  <= '0;
                        col_q   <= '0;
                        phase_q <= (phase_q == phase_t'(PHASES - 1)) ?
                                   '0 : phase_t'(phase_q + 1'b1);
                    end else if (row_end) begin
                        fill_q <= fill_t'(fill_q + 1'b1);
                    end
                end
                default: state_q <= SEQ_INIT_FILL;
            endcase
        end
    end

    // Distance of the write slot past the oldest row of the band
    assign wr_offset = (int'(wr_slot_q) + SLOTS - int'(base_slot)) % SLOTS;

    a_wr_outside_band: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (bus.rd_en && bus.wr_en) |-> (wr_offset >= TILE)
    ) else $error("write into slot %0d of the band being read", wr_slot_q);

endmodule

`default_nettype wire

//--- rtl/tile_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module tile_assembler import tile_pkg::*; #(
    parameter int CHANNELS = DEF_CHANNELS,
    parameter int TILE     = DEF_TILE
) (
    input  wire logic                                   i_clk,
    input  wire logic                                   i_rst,
    input  wire logic                                   i_rd_valid,
    input  wire logic [CHANNELS*TILE*TILE*PIXEL_W-1:0]  i_rd_rows,
    output logic                                        o_free,
    output logic      [CHANNELS*TILE*TILE*PIXEL_W-1:0]  o_tile,
    output logic                                        o_tile_req,
    input  wire logic                                   i_tile_ack
);

    hs_state_e state_q;
    // Next tile already captured while the previous ack is still high
    logic      pending_q;

    always_ff @(posedge i_clk) begin
        if (i_rd_valid) begin
            o_tile <= i_rd_rows;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q   <= HS_IDLE;
            pending_q <= 1'b0;
        end else begin
            case (state_q)
                HS_IDLE: begin
                    if (i_rd_valid) begin
                        state_q <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (i_tile_ack) begin
                        state_q <= HS_WAIT_ACK_LOW;
                    end
                end
                HS_WAIT_ACK_LOW: begin
                    if (!i_tile_ack) begin
                        state_q   <= (pending_q || i_rd_valid) ? HS_REQ : HS_IDLE;
                        pending_q <= 1'b0;
                    end else if (i_rd_valid) begin
                        pending_q <= 1'b1;
                    end
                end
                default: state_q <= HS_IDLE;
            endcase
        end
    end

    assign o_tile_req = (state_q == HS_REQ);

    // Free once the held tile is acked and no read is on its way
    assign o_free = ((state_q == HS_IDLE) || (state_q == HS_WAIT_ACK_LOW)) &&
                    !pending_q && !i_rd_valid;

    a_tile_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_tile_req && !i_tile_ack) |=> $stable(o_tile)
    ) else $error("o_tile changed during an open request");

    // Sequencer only reads when free, so a capture never hits a live tile
    a_no_overrun: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_rd_valid |-> ((state_q != HS_REQ) && !pending_q)
    ) else $error("tile returned while the holding register was busy");

endmodule

`default_nettype wire

//--- rtl/tile_window_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tile_window_unit import tile_pkg::*; #(
    parameter int CHANNELS = DEF_CHANNELS,
    parameter int WIDTH    = DEF_WIDTH,
    parameter int TILE     = DEF_TILE,
    parameter int STRIDE   = DEF_STRIDE
) (
    input  wire logic                                   i_clk,
    input  wire logic                                   i_rst,
    input  wire logic                                   i_restart,
    input  wire pixel_t                                 i_pixel,
    input  wire logic                                   i_pixel_valid,
    output logic                                        o_pixel_ready,
    output logic      [CHANNELS*TILE*TILE*PIXEL_W-1:0]  o_tile,
    output logic                                        o_tile_req,
    input  wire logic                                   i_tile_ack
);

    logic free;

    row_bank_if #(
        .CHANNELS (CHANNELS),
        .WIDTH    (WIDTH),
        .TILE     (TILE),
        .STRIDE   (STRIDE)
    ) bank_bus ();

    bank_sequencer #(
        .CHANNELS (CHANNELS),
        .WIDTH    (WIDTH),
        .TILE     (TILE),
        .STRIDE   (STRIDE)
    ) u_sequencer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_restart     (i_restart),
        .i_pixel       (i_pixel),
        .i_pixel_valid (i_pixel_valid),
        .o_pixel_ready (o_pixel_ready),
        .i_free        (free),
        .bus           (bank_bus.seq)
    );

    row_bank #(
        .CHANNELS (CHANNELS),
        .WIDTH    (WIDTH),
        .TILE     (TILE),
        .STRIDE   (STRIDE)
    ) u_row_bank (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .bus   (bank_bus.bank)
    );

    tile_assembler #(
        .CHANNELS (CHANNELS),
        .TILE     (TILE)
    ) u_assembler (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rd_valid (bank_bus.rd_valid),
        .i_rd_rows  (bank_bus.rd_rows),
        .o_free     (free),
        .o_tile     (o_tile),
        .o_tile_req (o_tile_req),
        .i_tile_ack (i_tile_ack)
    );

endmodule

`default_nettype wire

//--- bench/tile_model.svh
// Image as the DUT accepted it, by channel, row and column
pixel_t img [CH][ROWS][W];
int     acc_count;
tile_t  exp_q [$];

task automatic clear_model();
    acc_count = 0;
    exp_q.delete();
endtask

// Element (ch, r, k) is image row S*band+r, column S*step+k
function automatic tile_t tile_at(int band, int step);
    tile_t t;
    int    row;
    int    col;
    t = '0;
    for (int ch = 0; ch < CH; ch++) begin
        for (int r = 0; r < N; r++) begin
            row = S * band + r;
            for (int k = 0; k < N; k++) begin
                col = S * step + k;
                t[((ch*N + r)*N + k)*PIXEL_W +: PIXEL_W] = img[ch][row][col];
            end
        end
    end
    return t;
endfunction

task automatic record_pixel(pixel_t p);
    int row;
    int pos;
    row = acc_count / ROW_PIX;
    pos = acc_count % ROW_PIX;
    if (row >= ROWS) begin
        abort_run("more pixels were accepted than one image holds");
    end
    // Channels arrive back to back within a row
    img[pos / W][row][pos % W] = p;
    acc_count++;
    // Bottom row of a band complete, its tiles become due
    if (pos == ROW_PIX - 1 && row + 1 >= N && (row + 1 - N) % S == 0) begin
        for (int c = 0; c < STEPS; c++) begin
            exp_q.push_back(tile_at((row + 1 - N) / S, c));
        end
    end
endtask

//--- bench/tb_tile_window_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tile_window_unit import tile_pkg::*; ();

    localparam int CH            = DEF_CHANNELS;
    localparam int W             = DEF_WIDTH;
    localparam int N             = DEF_TILE;
    localparam int S             = DEF_STRIDE;
    localparam int ROWS          = 12;
    localparam int ROW_PIX       = CH * W;
    localparam int IMG_PIX       = ROWS * ROW_PIX;
    localparam int STEPS         = (W - N) / S + 1;
    localparam int TILES_PER_IMG = ((ROWS - N) / S + 1) * STEPS;
    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int MAX_ACK_DELAY = 48;
    localparam int IMAGES        = 3;
    localparam int LIMIT_CYCLES  = (IMAGES * IMG_PIX + IMAGES * TILES_PER_IMG * MAX_ACK_DELAY) * 4;

    typedef logic [CH*N*N*PIXEL_W-1:0] tile_t;

    logic   i_clk;
    logic   i_rst;
    logic   i_restart;
    pixel_t i_pixel;
    logic   i_pixel_valid;
    logic   o_pixel_ready;
    tile_t  o_tile;
    logic   o_tile_req;
    logic   i_tile_ack;

    integer seed = 43;
    pixel_t stim [IMG_PIX];
    tile_t  held_tile;
    int     tiles_seen;
    int     ack_max;
    logic   req_prev;
    logic   ack_prev;
    logic   ready_low_seen;

    `include "tile_model.svh"

    tile_window_unit DUT (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_restart     (i_restart),
        .i_pixel       (i_pixel),
        .i_pixel_valid (i_pixel_valid),
        .o_pixel_ready (o_pixel_ready),
        .o_tile        (o_tile),
        .o_tile_req    (o_tile_req),
        .i_tile_ack    (i_tile_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_tile(string name, tile_t expected, tile_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t %s expected %h actual %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t %s expected %b actual %b",
                                $time, name, expected, actual));
        end
    endtask

    function automatic int random_upto(int max);
        return $unsigned($random(seed)) % (max + 1);
    endfunction

    task automatic make_image();
        for (int i = 0; i < IMG_PIX; i++) begin
            stim[i] = pixel_t'($random(seed));
        end
    endtask

    // Holds one pixel until the DUT takes it and returns at the drive point
    task automatic send_image(bit with_gaps);
        logic taken;
        for (int i = 0; i < IMG_PIX; i++) begin
            if (with_gaps && random_upto(3) == 0) begin
                i_pixel_valid = 1'b0;
                repeat (1 + random_upto(2)) begin
                    @(posedge i_clk);
                    #DRIVE_DLY;
                end
            end
            i_pixel       = stim[i];
            i_pixel_valid = 1'b1;
            taken         = 1'b0;
            while (!taken) begin
                @(negedge i_clk);
                taken = o_pixel_ready;
                @(posedge i_clk);
                #DRIVE_DLY;
            end
        end
        i_pixel_valid = 1'b0;
    endtask

    task automatic wait_for_tiles();
        while (tiles_seen < TILES_PER_IMG || o_tile_req || i_tile_ack) begin
            @(negedge i_clk);
        end
        if (acc_count != IMG_PIX || exp_q.size() != 0) begin
            abort_run($sformatf("image ended with %0d pixels accepted and %0d tiles missing",
                                acc_count, exp_q.size()));
        end
        @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic restart_unit();
        clear_model();
        tiles_seen = 0;
        i_restart  = 1'b1;
        @(posedge i_clk);
        #DRIVE_DLY;
        i_restart = 1'b0;
    endtask

    // Accepted pixels, tile arrivals and the four-phase rule sampled mid-cycle
    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (i_pixel_valid && o_pixel_ready && !i_restart) begin
                record_pixel(i_pixel);
            end
            if (!o_pixel_ready) begin
                ready_low_seen = 1'b1;
            end
            // Ack as the DUT saw it on the edge just passed
            if (!req_prev && ack_prev) begin
                check_bit("o_tile_req", 1'b0, o_tile_req);
            end
            if (o_tile_req && !req_prev) begin
                if (exp_q.size() == 0) begin
                    abort_run("tile requested before the rows of its band were accepted");
                end
                held_tile = exp_q.pop_front();
                check_tile("o_tile", held_tile, o_tile);
                tiles_seen++;
            end else if (o_tile_req && !i_tile_ack) begin
                check_tile("o_tile", held_tile, o_tile);
            end
            req_prev = o_tile_req;
            ack_prev = i_tile_ack;
        end
    end

    // Consumer with a random delay before raising and before dropping ack
    initial begin
        forever begin
            @(negedge i_clk);
            if (o_tile_req && !i_tile_ack) begin
                repeat (random_upto(ack_max)) @(posedge i_clk);
                @(posedge i_clk);
                #DRIVE_DLY;
                i_tile_ack = 1'b1;
                do @(negedge i_clk); while (o_tile_req);
                repeat (random_upto(ack_max)) @(posedge i_clk);
                @(posedge i_clk);
                #DRIVE_DLY;
                i_tile_ack = 1'b0;
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired, the run hung waiting on the DUT");
    end

    initial begin
        i_rst          = 1'b1;
        i_restart      = 1'b0;
        i_pixel        = '0;
        i_pixel_valid  = 1'b0;
        i_tile_ack     = 1'b0;
        ack_max        = 0;
        tiles_seen     = 0;
        req_prev       = 1'b0;
        ack_prev       = 1'b0;
        ready_low_seen = 1'b0;
        held_tile      = '0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst = 1'b0;
        @(negedge i_clk);
        check_bit("o_tile_req", 1'b0, o_tile_req);
        check_bit("o_pixel_ready", 1'b1, o_pixel_ready);
        @(posedge i_clk);
        #DRIVE_DLY;

        // Back to back pixels and an immediate ack
        make_image();
        send_image(1'b0);
        wait_for_tiles();

        // Same image again with input gaps and slow acks
        restart_unit();
        ack_max        = MAX_ACK_DELAY;
        ready_low_seen = 1'b0;
        send_image(1'b1);
        wait_for_tiles();
        if (!ready_low_seen) begin
            abort_run("o_pixel_ready never dropped while acks were slow");
        end

        // New image after restart starts from its first band
        restart_unit();
        ack_max = 3;
        make_image();
        send_image(1'b1);
        wait_for_tiles();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
rtl/tile_pkg.sv
rtl/row_bank_if.sv
rtl/row_buffer.sv
rtl/row_bank.sv
rtl/bank_sequencer.sv
rtl/tile_assembler.sv
rtl/tile_window_unit.sv
bench/tb_tile_window_unit.sv

//--- Bender.yml
package:
  name: tile_window_unit

sources:
  - rtl/tile_pkg.sv
  - rtl/row_bank_if.sv
  - rtl/row_buffer.sv
  - rtl/row_bank.sv
  - rtl/bank_sequencer.sv
  - rtl/tile_assembler.sv
  - rtl/tile_window_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_tile_window_unit.sv
